/* compile.f */
source/otp_lc_pkg.sv
source/otp_word_counter.sv
source/otp_macro_model.sv
source/otp_lc_writer.sv
source/otp_lc_top.sv
tests/otp_lc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the LC write path testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert \
    -f compile.f \
    --top-module otp_lc_tb \
    -o otp_lc_sim &&
  ./obj_dir/otp_lc_sim ||
  { echo "Simulation failed" >&2; exit 1; }

/* tests/otp_lc_tb.sv */
//////////////////////////////
// Testbench for the LC write path
// Clock, reset, LFSR stimulus, fuse reference model and checks
//////////////////////////////

`timescale 1ns/1ps

module otp_lc_tb import otp_lc_pkg::*; ();

  localparam int NumLcWords  = 4;
  localparam int LcOffset    = 8;
  localparam int NumOtpWords = 32;
  localparam int LcBits      = NumLcWords * OtpWidth;
  localparam int NumRandTx   = 6;
  // Clean writes, blank error, its retry, idle escalation, two mid escalations, one prep write
  localparam int NumTx         = NumRandTx + 6;
  localparam int TimeoutCycles = 40 * NumTx * NumLcWords;
  // Longer than a full transfer of 3 cycles per word
  localparam int NoAckWindow = 3 * NumLcWords + 10;
  // Escalation lands inside the second word
  localparam int MidCycles = 5;

  logic              clk_i;
  logic              rst_ni;
  logic              lci_en_i;
  logic              escalate_en_i;
  logic              lc_req_i;
  logic [LcBits-1:0] lc_data_i;
  logic              lc_ack_o;
  logic              lc_err_o;
  otp_err_e          error_o;
  logic              fsm_err_o;
  logic              lci_prog_idle_o;

  // Expected outcome of one LC transition
  typedef struct packed {
    logic              err;
    logic [LcBits-1:0] words;
  } lc_ref_t;

  logic [LcBits-1:0] stored;
  logic [15:0]       lfsr_q;
  logic              ack_allowed;
  logic              exp_lc_err;
  otp_err_e          exp_error;
  otp_err_e          ack_exp_error;
  int                ack_count;
  int                acks_expected;
  int                cycle_cnt;

  otp_lc_top #(
    .NumLcWords  (NumLcWords),
    .LcOffset    (LcOffset),
    .NumOtpWords (NumOtpWords)
  ) u_otp_lc_top (
    .clk_i,
    .rst_ni,
    .lci_en_i,
    .escalate_en_i,
    .lc_req_i,
    .lc_data_i,
    .lc_ack_o,
    .lc_err_o,
    .error_o,
    .fsm_err_o,
    .lci_prog_idle_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_check(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Check failed");
  endtask

  // Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int nbits, output logic [LcBits-1:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val    = {val[LcBits-2:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Fuses only go 0 to 1, clearing a blown bit is an error
  function automatic lc_ref_t lc_reference(input logic [LcBits-1:0] old_words,
                                           input logic [LcBits-1:0] new_words);
    lc_ref_t r;
    r.err   = |(old_words & ~new_words);
    r.words = old_words | new_words;
    return r;
  endfunction

  // First set bit at or after start, wrapping within span, -1 if none
  function automatic int find_set_bit(input logic [LcBits-1:0] val, input int start,
                                      input int span);
    logic [LcBits-1:0] sh;
    for (int i = 0; i < span; i++) begin
      sh = val >> ((start + i) % span);
      if (sh[0]) begin
        return (start + i) % span;
      end
    end
    return -1;
  endfunction

  //////////////////////////////
  // Sequences
  //////////////////////////////

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    lci_en_i      <= 1'b0;
    escalate_en_i <= 1'b0;
    lc_req_i      <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Macro model blanks its array on reset
    stored = '0;
  endtask

  task automatic enable_lci();
    @(posedge clk_i);
    lci_en_i <= 1'b1;
    do @(negedge clk_i); while (!lci_prog_idle_o);
  endtask

  // Full request with ack, reference model updated afterwards
  task automatic transfer(input logic [LcBits-1:0] data);
    lc_ref_t r;
    r           = lc_reference(stored, data);
    exp_lc_err  = r.err;
    exp_error   = r.err ? MacroWriteBlankError : NoError;
    ack_allowed = 1'b1;
    acks_expected++;
    @(posedge clk_i);
    lc_req_i  <= 1'b1;
    lc_data_i <= data;
    do @(negedge clk_i); while (!lc_ack_o);
    @(posedge clk_i);
    lc_req_i <= 1'b0;
    stored = r.words;
    @(negedge clk_i);
    assert (lci_prog_idle_o == !r.err)
      else fail_check($sformatf("idle is %0b after ack", lci_prog_idle_o));
  endtask

  // Locked writer must ignore the request
  task automatic check_no_ack(input logic [LcBits-1:0] data);
    ack_allowed = 1'b0;
    @(posedge clk_i);
    lc_req_i  <= 1'b1;
    lc_data_i <= data;
    repeat (NoAckWindow) begin
      @(negedge clk_i);
      assert (!lci_prog_idle_o) else fail_check("idle high in the error state");
    end
    @(posedge clk_i);
    lc_req_i <= 1'b0;
  endtask

  task automatic escalate_mid_transfer(input logic [LcBits-1:0] data);
    lc_ref_t  r;
    otp_err_e exp_final;
    r = lc_reference(stored, data);
    // A blank error latched before escalation is kept
    exp_final   = r.err ? MacroWriteBlankError : FsmStateError;
    ack_allowed = 1'b0;
    @(posedge clk_i);
    lc_req_i  <= 1'b1;
    lc_data_i <= data;
    repeat (MidCycles) @(posedge clk_i);
    escalate_en_i <= 1'b1;
    @(negedge clk_i);
    assert (fsm_err_o) else fail_check("fsm_err_o low during escalation");
    @(posedge clk_i);
    escalate_en_i <= 1'b0;
    lc_req_i      <= 1'b0;
    @(negedge clk_i);
    assert (error_o == exp_final)
      else fail_check($sformatf("error_o %s, expected %s", error_o.name(), exp_final.name()));
    check_no_ack(data);
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && lc_ack_o) begin
      assert (ack_allowed) else fail_check("ack while none was expected");
      assert (lc_err_o == exp_lc_err)
        else fail_check($sformatf("lc_err_o %0b, expected %0b", lc_err_o, exp_lc_err));
      ack_count++;
      // Expected code of this ack, the next transfer may set up its own meanwhile
      ack_exp_error = exp_error;
      // Error code register updates on the ack edge
      @(negedge clk_i);
      assert (error_o == ack_exp_error)
        else fail_check($sformatf("error_o %s, expected %s",
                                  error_o.name(), ack_exp_error.name()));
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Test failed");
      $fatal(1, "Timeout, run did not finish within %0d cycles", TimeoutCycles);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [LcBits-1:0] r1;
    logic [LcBits-1:0] r2;
    logic [LcBits-1:0] data;
    logic [LcBits-1:0] mask;
    int                k;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = 1'b0;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    lfsr_q        = 16'd67;
    ack_allowed   = 1'b0;
    exp_lc_err    = 1'b0;
    exp_error     = NoError;
    ack_exp_error = NoError;
    ack_count     = 0;
    acks_expected = 0;
    cycle_cnt     = 0;
    stored        = '0;
    apply_reset();

    // Held in reset state until enabled
    repeat (3) begin
      @(negedge clk_i);
      assert (!lci_prog_idle_o && !lc_ack_o && error_o == NoError)
        else fail_check("outputs not quiet before enable");
    end
    enable_lci();

    // Monotonic transitions
    data = '0;
    for (int t = 0; t < NumRandTx; t++) begin
      draw_bits(LcBits, r1);
      draw_bits(LcBits, r2);
      data = data | (r1 & r2);
      transfer(data);
    end

    // Clear one blown bit
    draw_bits(6, r1);
    k = find_set_bit(stored, int'(r1[5:0]), LcBits);
    assert (k >= 0) else fail_check("reference holds no programmed bit");
    mask = {{(LcBits-1){1'b0}}, 1'b1} << k;
    draw_bits(LcBits, r2);
    transfer((stored | r2) & ~mask);
    check_no_ack(stored);

    // Escalation while idle
    apply_reset();
    enable_lci();
    @(posedge clk_i);
    escalate_en_i <= 1'b1;
    @(negedge clk_i);
    assert (fsm_err_o) else fail_check("fsm_err_o low during escalation");
    @(posedge clk_i);
    escalate_en_i <= 1'b0;
    @(negedge clk_i);
    assert (!fsm_err_o && error_o == FsmStateError)
      else fail_check($sformatf("error_o %s after idle escalation", error_o.name()));
    draw_bits(LcBits, r1);
    check_no_ack(r1);

    // Escalation during a clean transition
    apply_reset();
    enable_lci();
    draw_bits(LcBits, r1);
    escalate_mid_transfer(r1);

    // Escalation after a blank error in word 0
    apply_reset();
    enable_lci();
    draw_bits(LcBits, r1);
    transfer(r1 | {{(LcBits-1){1'b0}}, 1'b1});
    draw_bits(4, r2);
    k = find_set_bit(stored, int'(r2[3:0]), OtpWidth);
    mask = {{(LcBits-1){1'b0}}, 1'b1} << k;
    draw_bits(LcBits, r2);
    escalate_mid_transfer((stored | r2) & ~mask);

    assert (ack_count == acks_expected)
      else fail_check($sformatf("%0d acks, expected %0d", ack_count, acks_expected));
    $display("Test passed");
    $finish;
  end

endmodule

/* source/otp_lc_top.sv */
//////////////////////////////
// LC write path top level
// Writer plus fuse macro model
//////////////////////////////

`timescale 1ns/1ps

module otp_lc_top
  import otp_lc_pkg::*;
#(
  parameter int NumLcWords  = 4,
  parameter int LcOffset    = 8,
  parameter int NumOtpWords = 32
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           lci_en_i,
  input  logic                           escalate_en_i,
  input  logic                           lc_req_i,
  input  logic [NumLcWords*OtpWidth-1:0] lc_data_i,
  output logic                           lc_ack_o,
  output logic                           lc_err_o,
  output otp_err_e                       error_o,
  output logic                           fsm_err_o,
  output logic                           lci_prog_idle_o
);

  // Macro port
  otp_cmd_t otp_cmd;
  logic     otp_gnt;
  otp_rsp_t otp_rsp;

  otp_lc_writer #(
    .NumLcWords (NumLcWords),
    .LcOffset   (LcOffset)
  ) u_otp_lc_writer (
    .clk_i,
    .rst_ni,
    .lci_en_i,
    .escalate_en_i,
    .lc_req_i,
    .lc_data_i,
    .lc_ack_o,
    .lc_err_o,
    .error_o,
    .fsm_err_o,
    .lci_prog_idle_o,
    .otp_cmd_o (otp_cmd),
    .otp_gnt_i (otp_gnt),
    .otp_rsp_i (otp_rsp)
  );

  otp_macro_model #(
    .NumOtpWords (NumOtpWords)
  ) u_otp_macro_model (
    .clk_i,
    .rst_ni,
    .otp_cmd_i (otp_cmd),
    .otp_gnt_o (otp_gnt),
    .otp_rsp_o (otp_rsp)
  );

endmodule

/* source/otp_lc_writer.sv */
//////////////////////////////
// Life cycle write path
// Splits the LC value into native words and burns them one by one
// Sparse FSM with terminal error state
//////////////////////////////

`timescale 1ns/1ps

module otp_lc_writer
  import otp_lc_pkg::*;
#(
  parameter int NumLcWords = 4,
  parameter int LcOffset   = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           lci_en_i,
  input  logic                           escalate_en_i,
  // LC controller side, level request and single cycle ack
  input  logic                           lc_req_i,
  input  logic [NumLcWords*OtpWidth-1:0] lc_data_i,
  output logic                           lc_ack_o,
  output logic                           lc_err_o,
  // Status
  output otp_err_e                       error_o,
  output logic                           fsm_err_o,
  output logic                           lci_prog_idle_o,
  // Macro side
  output otp_cmd_t                       otp_cmd_o,
  input  logic                           otp_gnt_i,
  input  otp_rsp_t                       otp_rsp_i
);

  localparam int CntWidth = (NumLcWords > 1) ? $clog2(NumLcWords) : 1;
  localparam logic [CntWidth-1:0] LastWord = CntWidth'(NumLcWords - 1);

  //////////////////////////////
  // FSM
  //////////////////////////////

  // Minimum Hamming distance 3 between any two codes
  typedef enum logic [5:0] {
    ResetSt     = 6'b000111,
    IdleSt      = 6'b011010,
    WriteSt     = 6'b101100,
    WriteWaitSt = 6'b110001,
    ErrorSt     = 6'b111111
  } state_e;

  state_e state_d, state_q;
  otp_err_e error_d, error_q;
  logic cnt_clr, cnt_incr, cnt_err;
  logic [CntWidth-1:0] cnt;
  logic otp_req;

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_incr        = 1'b0;
    otp_req         = 1'b0;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;
    lci_prog_idle_o = 1'b0;

    unique case (state_q)
      // Hold until the LC interface is enabled
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Request is only looked at here
      IdleSt: begin
        lci_prog_idle_o = 1'b1;
        if (lc_req_i) begin
          cnt_clr = 1'b1;
          state_d = WriteSt;
        end
      end
      // Command held until the macro grants it
      WriteSt: begin
        otp_req = 1'b1;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      WriteWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          // Keep the macro error but carry on with the other words
          if (otp_rsp_i.err != NoError) begin
            error_d = otp_rsp_i.err;
          end
          if (cnt == LastWord) begin
            lc_ack_o = 1'b1;
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end else begin
              state_d = IdleSt;
            end
          end else begin
            cnt_incr = 1'b1;
            state_d  = WriteSt;
          end
        end
      end
      // Terminal, partition locked
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
    endcase

    // Escalation and counter faults override everything above
    if (escalate_en_i || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

  assign error_o = error_q;

  //////////////////////////////
  // Word counter and command
  //////////////////////////////

  otp_word_counter #(
    .Width(CntWidth)
  ) u_otp_word_counter (
    .clk_i,
    .rst_ni,
    .clr_i  (cnt_clr),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  logic [NumLcWords-1:0][OtpWidth-1:0] lc_words;
  assign lc_words = lc_data_i;

  // Partition base plus word index; data bus idles at zero
  assign otp_cmd_o = '{
    req:   otp_req,
    addr:  OtpAddrWidth'(LcOffset) + OtpAddrWidth'(cnt),
    wdata: otp_req ? lc_words[cnt] : '0
  };

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // A new write only starts from Idle or after the previous response
  req_rise_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(otp_cmd_o.req) |->
      (state_q == WriteSt) && ($past(state_q) inside {IdleSt, WriteWaitSt}));

  // Ack is a single cycle pulse
  ack_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_o |=> !lc_ack_o);

endmodule

/* source/otp_macro_model.sv */
//////////////////////////////
// Behavioral fuse macro
// One-way bit programming, same cycle grant, 2 cycle response
//////////////////////////////

`timescale 1ns/1ps

module otp_macro_model
  import otp_lc_pkg::*;
#(
  parameter int NumOtpWords = 32
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  otp_cmd_t otp_cmd_i,
  output logic     otp_gnt_o,
  output otp_rsp_t otp_rsp_o
);

  // Fuse array, blank after reset
  logic [NumOtpWords-1:0][OtpWidth-1:0] fuse_q;

  // Response pipeline, stage 1 is the last entry
  logic [1:0]                   vld_q;
  logic [1:0][OtpAddrWidth-1:0] addr_q;
  logic [1:0][OtpWidth-1:0]     wdata_q;

  logic [OtpWidth-1:0] old_word;
  logic                blank_err;

  //////////////////////////////
  // Grant
  //////////////////////////////

  // One write in flight at a time
  assign otp_gnt_o = otp_cmd_i.req && (vld_q == 2'b00);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= 2'b00;
    end else begin
      vld_q <= {vld_q[0], otp_gnt_o};
    end
  end

  // Payload just follows along
  always_ff @(posedge clk_i) begin
    addr_q  <= {addr_q[0], otp_cmd_i.addr};
    wdata_q <= {wdata_q[0], otp_cmd_i.wdata};
  end

  //////////////////////////////
  // Programming
  //////////////////////////////

  assign old_word = fuse_q[addr_q[1]];

  // Any blown bit that the new word wants cleared
  assign blank_err = |(old_word & ~wdata_q[1]);

  // Array changes in the cycle the response leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fuse_q <= '0;
    end else if (vld_q[1]) begin
      fuse_q[addr_q[1]] <= old_word | wdata_q[1];
    end
  end

  assign otp_rsp_o.rvalid = vld_q[1];
  assign otp_rsp_o.err    = (vld_q[1] && blank_err) ? MacroWriteBlankError : NoError;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  addr_range_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_cmd_i.req |-> (int'(otp_cmd_i.addr) < NumOtpWords));

endmodule

/* source/otp_word_counter.sv */
//////////////////////////////
// Redundant word counter
// Count plus inverted shadow copy, flags any disagreement
//////////////////////////////

`timescale 1ns/1ps

module otp_word_counter #(
  parameter int Width = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clr_i,
  input  logic             incr_i,
  output logic [Width-1:0] cnt_o,
  output logic             err_o
);

  logic [Width-1:0] cnt_d;
  logic [Width-1:0] cnt_q;
  // Shadow copy, always stored inverted
  logic [Width-1:0] cnt_n_q;

  // Next count, clear wins over increment
  always_comb begin
    cnt_d = cnt_q;
    if (clr_i) begin
      cnt_d = '0;
    end else if (incr_i) begin
      cnt_d = cnt_q + Width'(1);
    end
  end

  // Both copies move on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else begin
      cnt_q   <= cnt_d;
      cnt_n_q <= ~cnt_d;
    end
  end

  assign cnt_o = cnt_q;

  // A flipped bit in either register shows up here
  assign err_o = (cnt_q != ~cnt_n_q);

  // The writer never clears and steps the counter in one cycle
  clr_incr_excl_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clr_i && incr_i));

endmodule

/* source/otp_lc_pkg.sv */
//////////////////////////////
// Shared OTP definitions
// Native word widths, partition error codes
// Command and response structs of the fuse macro port
//////////////////////////////

package otp_lc_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // One native fuse word
  parameter int OtpWidth = 16;

  // Word address into the macro
  parameter int OtpAddrWidth = 8;

  //////////////////////////////
  // Error codes
  //////////////////////////////

  // Partition error code, also returned by the macro per write
  typedef enum logic [1:0] {
    NoError              = 2'b00,
    // Write tried to clear a fuse bit that is already blown
    MacroWriteBlankError = 2'b01,
    // Glitched FSM, escalation or counter fault
    FsmStateError        = 2'b10
  } otp_err_e;

  //////////////////////////////
  // Macro port
  //////////////////////////////

  // Writer to macro, held stable until granted
  typedef struct packed {
    logic                    req;
    logic [OtpAddrWidth-1:0] addr;
    logic [OtpWidth-1:0]     wdata;
  } otp_cmd_t;

  // Macro to writer, one response per granted write
  typedef struct packed {
    logic     rvalid;
    // Only meaningful while rvalid is high
    otp_err_e err;
  } otp_rsp_t;

endpackage
